// ==== fpDivUnit.f ====
+incdir+.
fpDivFormatPkg.sv
fpDivCtrlPkg.sv
divSequencer.sv
divIterCounter.sv
divRecurrence.sv
divShiftCalc.sv
divPostProc.sv
fpDivUnit.sv
fpDivUnit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the divider and its testbench with Verilator, then run it
# the log decides the result, since a failing check also ends the run
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fpDivUnit.f --top-module fpDivUnit_tb \
    && (./obj_dir/VfpDivUnit_tb > sim.log 2>&1 || true) \
    && cat sim.log \
    && grep -q '^PASS: all tests$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== fpDivUnit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module fpDivUnit_tb;
    import fpDivFormatPkg::*;
    import fpDivCtrlPkg::*;

    localparam int clkPeriod = 10;
    // edge that samples start to the cycle with done
    localparam int latency = `DIVb + 2;
    // extra model quotient bits, far below the round position
    localparam int guardShift = 40;
    localparam int numRandom = 200;
    localparam int numBelowOne = 40;
    localparam int numSubnormal = 60;
    localparam int numOverflow = 30;
    localparam int numTies = 10;
    localparam int numIgnored = 4;
    localparam int numTests = numRandom + numBelowOne + numSubnormal + numOverflow
                              + numTies + numIgnored;
    localparam int cyclesPerTest = 20;
    localparam int marginCycles = 1000;
    // quiet cycles after done for a stray start to show up
    localparam int settleCycles = 20;

    logic   clk = 1'b0;
    logic   rstN;
    logic   start;
    divReqT req;
    logic   busy;
    logic   done;
    divResT res;

    int seed = 93;
    int doneCount = 0;
    int errorCount = 0;

    fpDivUnit uut (
        .clk(clk), .rstN(rstN), .start(start), .req(req),
        .busy(busy), .done(done), .res(res)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // every done strobe, accepted or not
    always @(negedge clk) begin
        if (done) begin
            doneCount <= doneCount + 1;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic int randRange(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'((r & 32'h7fffffff) % (hi - lo + 1));
    endfunction

    function automatic fpWordT makeWord(input logic s, input int e, input int f);
        fpWordT w;
        w.sign = s;
        w.exp  = expT'(e);
        w.frac = fracT'(f);
        return w;
    endfunction

    function automatic fpWordT randomOperand(input int expLo, input int expHi);
        logic s;
        s = randRange(0, 1) != 0;
        return makeWord(s, randRange(expLo, expHi), randRange(0, (1 << `NF) - 1));
    endfunction

    // correctly rounded quotient from exact integer division
    function automatic fpWordT modelDivide(input fpWordT a, input fpWordT b);
        sigT         sigA;
        sigT         sigB;
        int          e;
        int          ex;
        int          eEff;
        int          sh;
        int          expOut;
        logic [63:0] num;
        logic [63:0] quo;
        logic [63:0] t;
        logic        rem;
        logic        guard;
        logic        lowBits;
        fpWordT      r;
        sigA = {1'b1, a.frac};
        sigB = {1'b1, b.frac};
        e = int'(a.exp) - int'(b.exp) + `BIAS;
        // quotient below one moves the exponent down
        ex = (sigA >= sigB) ? e : e - 1;
        // subnormals share the scale of exponent one
        eEff = (ex < 1) ? 1 : ex;
        // target integer holds NF bits below the hidden one position
        sh = e + `NF - eEff;
        num = 64'(sigA) << (sh + guardShift);
        quo = num / 64'(sigB);
        rem = (num % 64'(sigB)) != 64'd0;
        t = quo >> guardShift;
        guard = quo[guardShift-1];
        lowBits = (quo[guardShift-2:0] != '0) || rem;
        // nearest, ties to even
        if (guard && (lowBits || t[0])) begin
            t = t + 64'd1;
        end
        // carry past the hidden one, or into it for a subnormal, bumps the exponent
        expOut = eEff - 1 + int'(t >> `NF);
        r.sign = a.sign ^ b.sign;
        if (expOut >= (1 << `NE) - 1) begin
            r.exp  = '1;
            r.frac = '0;
        end else begin
            r.exp  = expT'(expOut);
            r.frac = t[`NF-1:0];
        end
        return r;
    endfunction

    // one division, optionally with a stray start while busy
    // the stray request is the operands swapped, so a wrong capture shows up
    task automatic runDivide(input string name, input fpWordT a, input fpWordT b,
                             input int strayCycle);
        divReqT first;
        divReqT stray;
        fpWordT expected;
        int     cycles;
        int     countBefore;
        first.dividend = a;
        first.divisor  = b;
        stray.dividend = b;
        stray.divisor  = a;
        expected = modelDivide(a, b);
        @(posedge clk);
        countBefore = doneCount;
        req   <= first;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            checkValue({name, " busy"}, 32'd1, 32'(busy));
            @(posedge clk);
            cycles++;
            if (cycles == strayCycle) begin
                req   <= stray;
                start <= 1'b1;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        checkValue({name, " latency"}, 32'(latency), 32'(cycles));
        checkValue({name, " busy at done"}, 32'd0, 32'(busy));
        checkValue({name, " result"}, 32'(expected), 32'(res.result));
        if (strayCycle != 0) begin
            repeat (settleCycles) @(posedge clk);
            checkValue({name, " done count"}, 32'(countBefore + 1), 32'(doneCount));
            checkValue({name, " busy after"}, 32'd0, 32'(busy));
        end
    endtask

    initial begin
        fpWordT a;
        fpWordT b;
        int     fa;
        int     fb;
        rstN  = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("reset busy", 32'd0, 32'(busy));
        checkValue("reset done", 32'd0, 32'(done));

        // full normal range on both operands
        for (int i = 0; i < numRandom; i++) begin
            runDivide($sformatf("random %0d", i), randomOperand(1, 30), randomOperand(1, 30), 0);
        end

        // dividend significand below the divisor one
        for (int i = 0; i < numBelowOne; i++) begin
            fb = randRange(1, (1 << `NF) - 1);
            fa = randRange(0, fb - 1);
            a = makeWord(randRange(0, 1) != 0, randRange(10, 20), fa);
            b = makeWord(randRange(0, 1) != 0, randRange(10, 20), fb);
            runDivide($sformatf("below one %0d", i), a, b, 0);
        end

        // quotient exponent from about -14 up to 3
        for (int i = 0; i < numSubnormal; i++) begin
            runDivide($sformatf("subnormal %0d", i), randomOperand(1, 8),
                      randomOperand(20, 30), 0);
        end

        for (int i = 0; i < numOverflow; i++) begin
            runDivide($sformatf("overflow %0d", i), randomOperand(25, 30),
                      randomOperand(1, 8), 0);
            checkValue($sformatf("overflow %0d exp", i), 32'd31, 32'(res.result.exp));
            checkValue($sformatf("overflow %0d frac", i), 32'd0, 32'(res.result.frac));
        end

        // exact halves only occur below the normal range
        runDivide("tie odd up", makeWord(1'b0, 1, 3), makeWord(1'b0, 16, 0), 0);
        runDivide("tie even stays", makeWord(1'b0, 1, 1), makeWord(1'b0, 16, 0), 0);
        runDivide("tie negative", makeWord(1'b1, 1, 3), makeWord(1'b0, 16, 0), 0);
        runDivide("tie shift two even", makeWord(1'b0, 1, 2), makeWord(1'b1, 17, 0), 0);
        runDivide("tie shift two odd", makeWord(1'b1, 1, 6), makeWord(1'b1, 17, 0), 0);
        runDivide("tie smallest", makeWord(1'b0, 1, 512), makeWord(1'b0, 25, 0), 0);
        runDivide("tie to zero", makeWord(1'b0, 1, 0), makeWord(1'b1, 26, 0), 0);
        // rounding carry lands on the smallest normal
        runDivide("tie carry", makeWord(1'b0, 1, 1023), makeWord(1'b0, 16, 0), 0);
        runDivide("tie carry negative", makeWord(1'b0, 3, 1023), makeWord(1'b1, 18, 0), 0);
        runDivide("minus one", makeWord(1'b1, 15, 0), makeWord(1'b0, 15, 0), 0);

        // stray start early, mid, late in ITER and during NORM
        for (int i = 0; i < numIgnored; i++) begin
            runDivide($sformatf("ignored start %0d", i), randomOperand(1, 30),
                      randomOperand(1, 30), 1 + 4 * i);
        end

        if (errorCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors were reported");
        end
    end

    // watchdog sized from the test count
    initial begin
        #(clkPeriod * (numTests * cyclesPerTest + marginCycles));
        $display("TIMEOUT: the tests did not finish in the expected number of cycles");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== fpDivUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module fpDivUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  fpDivCtrlPkg::divReqT req,
    output logic                 busy,
    output logic                 done,
    output fpDivCtrlPkg::divResT res
);
    import fpDivFormatPkg::*;

    // sequencer controls
    logic                       load;
    logic                       enable;
    logic                       init;
    logic                       finish;
    logic                       lastStep;

    // recurrence results
    logic [`DIVb:0]             DivQm;
    logic                       sticky;
    quoExpT                     DivQe;
    logic                       sign;

    // shift calculation results
    logic [`LOGNORMSHIFTSZ-1:0] DivShiftAmt;
    logic [`NORMSHIFTSZ-1:0]    DivShiftIn;
    logic                       DivResDenorm;
    logic                       DivDenormShiftPos;

    divSequencer uSeq (
        .clk(clk), .rstN(rstN), .start(start), .lastStep(lastStep),
        .busy(busy), .done(done), .load(load), .enable(enable),
        .init(init), .finish(finish)
    );

    divIterCounter uCnt (
        .clk(clk), .rstN(rstN), .load(load), .enable(enable), .lastStep(lastStep)
    );

    // the counter enable doubles as the recurrence step
    divRecurrence uRec (
        .clk(clk), .rstN(rstN), .init(init), .step(enable), .req(req),
        .DivQm(DivQm), .sticky(sticky), .DivQe(DivQe), .sign(sign)
    );

    divShiftCalc uShift (
        .DivQm(DivQm), .DivQe(DivQe), .DivShiftAmt(DivShiftAmt), .DivShiftIn(DivShiftIn),
        .DivResDenorm(DivResDenorm), .DivDenormShiftPos(DivDenormShiftPos)
    );

    divPostProc uPost (
        .clk(clk), .rstN(rstN), .finish(finish), .DivShiftAmt(DivShiftAmt),
        .DivShiftIn(DivShiftIn), .DivResDenorm(DivResDenorm),
        .DivDenormShiftPos(DivDenormShiftPos), .DivQe(DivQe), .sticky(sticky),
        .sign(sign), .res(res)
    );

endmodule

`default_nettype wire

// ==== divPostProc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module divPostProc (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        finish,
    input  logic [`LOGNORMSHIFTSZ-1:0]  DivShiftAmt,
    input  logic [`NORMSHIFTSZ-1:0]     DivShiftIn,
    input  logic                        DivResDenorm,
    input  logic                        DivDenormShiftPos,
    input  fpDivFormatPkg::quoExpT      DivQe,
    input  logic                        sticky,
    input  logic                        sign,
    output fpDivCtrlPkg::divResT        res
);
    import fpDivFormatPkg::*;

    logic [`NORMSHIFTSZ-1:0] shifted;
    logic [`NORMSHIFTSZ-1:0] normW;
    logic                    corr;
    logic                    subn;
    logic                    rnd;
    logic                    stk;
    logic                    roundUp;
    logic                    carry;
    logic                    ovf;
    quoExpT                  preExp;
    quoExpT                  expSum;
    fracT                    frac;
    fracT                    fracRnd;
    fpWordT                  word;

    assign shifted = DivShiftIn << DivShiftAmt;

    // normal quotient below one, shift once more and lower the exponent
    assign corr  = ~DivResDenorm & ~shifted[`NORMSHIFTSZ-1];
    assign normW = corr ? {shifted[`NORMSHIFTSZ-2:0], 1'b0} : shifted;

    // DivQe is at least one on the normal path, so this stays non-negative
    assign preExp = DivResDenorm ? '0 : DivQe - {{(`NE+1){1'b0}}, corr};
    // exponent zero also covers a corrected quotient at DivQe of one
    assign subn   = (preExp == '0);

    always_comb begin
        if (subn) begin
            // no hidden one, fraction starts at the msb
            frac = normW[`NORMSHIFTSZ-1 -: `NF];
            // below the representable range the round bit is not real
            rnd  = normW[`NORMSHIFTSZ-1-`NF] & DivDenormShiftPos;
            stk  = (|normW[`NORMSHIFTSZ-2-`NF:0]) | sticky;
        end else begin
            // hidden one at the msb
            frac = normW[`NORMSHIFTSZ-2 -: `NF];
            rnd  = normW[`NORMSHIFTSZ-2-`NF];
            stk  = (|normW[`NORMSHIFTSZ-3-`NF:0]) | sticky;
        end
    end

    // nearest even, ties go to a zero lsb
    assign roundUp = rnd & (stk | frac[0]);
    assign {carry, fracRnd} = {1'b0, frac} + {{`NF{1'b0}}, roundUp};

    // carry out leaves a zero fraction, one more on the exponent
    // for a subnormal this lands exactly on the smallest normal
    assign expSum = preExp + {{(`NE+1){1'b0}}, carry};

    // all ones exponent and above is infinity
    assign ovf = (expSum >= quoExpT'((1 << `NE) - 1));

    always_comb begin
        word.sign = sign;
        word.exp  = ovf ? '1 : expSum[`NE-1:0];
        word.frac = ovf ? '0 : fracRnd;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            res <= '0;
        end else if (finish) begin
            // held until the next division finishes
            res.result <= word;
        end
    end

endmodule

`default_nettype wire

// ==== divShiftCalc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module divShiftCalc (
    input  logic [`DIVb:0]               DivQm,
    input  fpDivFormatPkg::quoExpT       DivQe,
    output logic [`LOGNORMSHIFTSZ-1:0]   DivShiftAmt,
    output logic [`NORMSHIFTSZ-1:0]      DivShiftIn,
    output logic                         DivResDenorm,
    output logic                         DivDenormShiftPos
);
    import fpDivFormatPkg::*;

    logic [`LOGNORMSHIFTSZ-1:0] denormShiftAmt;
    quoExpT                     denormShift;

    // zero or negative exponent gives a subnormal or zero result
    assign DivResDenorm = DivQe[`NE+1] | ~|DivQe;

    // subnormal case
    //   integer bit sits NF above the shifter msb window
    //   shifting by NF+DivQe lines it up one place above the subnormal fraction
    //   post-processing takes the fraction one bit higher for exponent zero
    assign denormShift       = quoExpT'(`NF) + DivQe;
    // negative shift means everything lands below the round position
    assign DivDenormShiftPos = ~denormShift[`NE+1];

    // keep the quotient unshifted, all of it then counts as sticky
    assign denormShiftAmt = DivDenormShiftPos ? denormShift[`LOGNORMSHIFTSZ-1:0] : '0;

    // normal case
    //   fixed shift of NF puts the integer bit at the msb
    //   a zero integer bit is fixed up after the shifter, exponent minus one
    assign DivShiftAmt = DivResDenorm ? denormShiftAmt : `LOGNORMSHIFTSZ'(`NF);

    // radix-2 layout only
    // NF zeros on top, the quotient, one spare zero at the bottom
    assign DivShiftIn = {{`NF{1'b0}}, DivQm, {(`NORMSHIFTSZ - `DIVb - 1 - `NF){1'b0}}};

endmodule

`default_nettype wire

// ==== divRecurrence.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module divRecurrence (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   init,
    input  logic                   step,
    input  fpDivCtrlPkg::divReqT   req,
    output logic [`DIVb:0]         DivQm,
    output logic                   sticky,
    output fpDivFormatPkg::quoExpT DivQe,
    output logic                   sign
);
    import fpDivFormatPkg::*;

    // divisor significand, held for the whole division
    sigT            divSig;
    // partial remainder, always below twice the divisor
    logic [`NF+1:0] remR;
    // trial difference, top bit is the borrow
    logic [`NF+2:0] diff;
    logic           qBit;
    logic [`NF+1:0] remNext;

    assign diff = {1'b0, remR} - {2'b00, divSig};
    // no borrow means the divisor fits
    assign qBit = ~diff[`NF+2];

    // restoring step, keep the difference or the old remainder, then double
    // both are below the divisor here, so the top bit drops safely
    assign remNext = qBit ? {diff[`NF:0], 1'b0} : {remR[`NF:0], 1'b0};

    always_ff @(posedge clk) begin
        if (init) begin
            // dividend significand with the hidden one
            remR   <= {1'b0, 1'b1, req.dividend.frac};
            divSig <= {1'b1, req.divisor.frac};
            DivQm  <= '0;
            // biased difference of exponents, may go negative
            DivQe  <= $signed({2'b00, req.dividend.exp}) - $signed({2'b00, req.divisor.exp})
                      + quoExpT'(`BIAS);
            sign   <= req.dividend.sign ^ req.divisor.sign;
        end else if (step) begin
            // msb first, integer bit ends up in DivQm[DIVb]
            DivQm <= {DivQm[`DIVb-1:0], qBit};
            remR  <= remNext;
        end
    end

    // any leftover remainder means the quotient is inexact
    assign sticky = |remR;

    // every step starts below twice the divisor, so each step yields one quotient bit
    remInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        step |-> (remR < {divSig, 1'b0})
    );

endmodule

`default_nettype wire

// ==== divIterCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module divIterCounter (
    input  logic clk,
    input  logic rstN,
    input  logic load,
    input  logic enable,
    output logic lastStep
);
    logic [`DURLEN-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            // integer bit plus DIVb fraction bits
            count <= `DURLEN'(`DIVb + 1);
        end else if (enable) begin
            count <= count - 1'b1;
        end
    end

    // the step that takes the count from one to zero is the last
    assign lastStep = (count == `DURLEN'(1));

    // sequencer must leave ITER before the counter runs dry
    noStepAtZero: assert property (
        @(posedge clk) disable iff (!rstN)
        enable |-> (count != '0)
    );

endmodule

`default_nettype wire

// ==== divSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fpDiv_config.svh"

module divSequencer (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic lastStep,
    output logic busy,
    output logic done,
    output logic load,
    output logic enable,
    output logic init,
    output logic finish
);
    import fpDivCtrlPkg::*;

    divStateT state;
    divStateT stateNext;
    logic     accept;

    // start only counts in IDLE
    assign accept = (state == IDLE) & start;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: if (start) stateNext = ITER;
            // stay until the counter flags its last step
            ITER: if (lastStep) stateNext = NORM;
            NORM: stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= stateNext;
            // done follows the NORM cycle, result register loads on the same edge
            done  <= (state == NORM);
        end
    end

    assign busy   = (state != IDLE);
    // counter load and operand capture share the accept edge
    assign load   = accept;
    assign init   = accept;
    // one quotient bit per ITER cycle
    assign enable = (state == ITER);
    assign finish = (state == NORM);

    // a single-cycle done strobe
    doneSinglePulse: assert property (
        @(posedge clk) disable iff (!rstN)
        done |=> !done
    );

    // a start while busy neither restarts nor shortens the running division
    startIgnoredBusy: assert property (
        @(posedge clk) disable iff (!rstN)
        accept |-> ##(`DIVb + 3) done
    );

endmodule

`default_nettype wire

// ==== fpDivCtrlPkg.sv ====
`default_nettype none

package fpDivCtrlPkg;

    // sequencer states
    // IDLE waits for start
    // ITER runs the recurrence, one quotient bit per cycle
    // NORM loads the post-processing register
    typedef enum logic [1:0] {
        IDLE,
        ITER,
        NORM
    } divStateT;

    // request sampled with start
    // dividend over divisor
    typedef struct packed {
        fpDivFormatPkg::fpWordT dividend;
        fpDivFormatPkg::fpWordT divisor;
    } divReqT;

    // result returned with done
    // held until the next done
    typedef struct packed {
        fpDivFormatPkg::fpWordT result;
    } divResT;

endpackage

`default_nettype wire

// ==== fpDivFormatPkg.sv ====
`default_nettype none

`include "fpDiv_config.svh"

package fpDivFormatPkg;

    // biased exponent field
    typedef logic [`NE-1:0] expT;

    // stored fraction, hidden one not included
    typedef logic [`NF-1:0] fracT;

    // significand with the hidden one
    typedef logic [`NF:0] sigT;

    // quotient exponent, two extra bits for range and sign
    // spans roughly -14 to 44 for normal operands
    typedef logic signed [`NE+1:0] quoExpT;

    // packed operand and result word, sign on top
    typedef struct packed {
        logic sign;
        expT  exp;
        fracT frac;
    } fpWordT;

endpackage

`default_nettype wire

// ==== fpDiv_config.svh ====
`ifndef FPDIV_CONFIG_SVH
`define FPDIV_CONFIG_SVH

// half-precision-like format
// exponent field width
`define NE 5
// stored fraction width
`define NF 10
// exponent bias
`define BIAS 15

// quotient bits below the integer position
// one guard and one extra bit beyond the fraction
`define DIVb (`NF + 2)

// normalization shifter width
// NF leading zeros, the quotient, one trailing zero
`define NORMSHIFTSZ (`DIVb + 1 + `NF + 1)
// shift amount width, indexes the shifter
`define LOGNORMSHIFTSZ ($clog2(`NORMSHIFTSZ))

// iteration counter width, holds DIVb+1 steps
`define DURLEN ($clog2(`DIVb + 2))

`endif
